// ==== build.f ====
display_pkg.sv
spi_pkg.sv
spi_link_if.sv
display_sequencer.sv
spi_bit_timer.sv
spi_word_shifter.sv
stopwatch_spi_top.sv
tb_stopwatch_spi.sv

// ==== display_pkg.sv ====
`default_nettype none

package display_pkg;

  //////////////////////////////
  // Digit widths and frame size
  //////////////////////////////
  localparam int DIGIT_W    = 4;                   // Full BCD digit, 0 to 9
  localparam int TENS6_W    = 3;                   // Tens of minutes and seconds, 0 to 5
  localparam int NUM_DIGITS = 6;                   // Words per frame
  localparam int IDX_W      = $clog2(NUM_DIGITS);  // Digit index width
  localparam int REG_W      = 8;                   // Address byte and data byte

  // Display register address
  typedef logic [REG_W-1:0] digit_addr_t;

  // Register map of the display driver
  localparam digit_addr_t      REG_DECODE_MODE = 8'h09;
  localparam logic [REG_W-1:0] DECODE_ALL_BCD  = 8'hFF;  // Code B decode on every digit

  // Digit snapshot, the first member goes out first on the wire
  // Digit n is written to display register n+1
  typedef struct packed {
    logic [DIGIT_W-1:0] cs_ones;   // Register 1
    logic [DIGIT_W-1:0] cs_tens;   // Register 2
    logic [DIGIT_W-1:0] sec_ones;  // Register 3
    logic [TENS6_W-1:0] sec_tens;  // Register 4
    logic [DIGIT_W-1:0] min_ones;  // Register 5
    logic [TENS6_W-1:0] min_tens;  // Register 6
  } digits_t;

endpackage

`default_nettype wire

// ==== display_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module display_sequencer (
  input  logic                 i_Clk,
  input  logic                 i_Rst_L,
  input  logic                 i_Frame_Tick,  // Slow tick, sampled as a level
  input  logic                 i_Enable,
  input  display_pkg::digits_t i_Digits,
  spi_link_if.seq              link
);

  import display_pkg::*;
  import spi_pkg::*;

  typedef enum logic [1:0] {
    SETUP,      // Decode mode word, once after reset
    IDLE,       // Wait for a frame tick
    ADDR_WAIT,  // Wait for the link, then issue the next digit word
    SEND        // Start is out, step the digit index
  } state_t;

  state_t           r_state;
  logic [IDX_W-1:0] r_digit_idx;
  logic             r_start;
  word_t            r_word;
  digits_t          r_digits;     // Frame snapshot

  logic r_tick_meta;
  logic r_tick_sync;
  logic r_tick_prev;
  logic r_tick_rise;

  logic               w_link_free;
  logic               w_accept;
  logic               w_load_setup;
  logic               w_load_digit;
  logic [DIGIT_W-1:0] w_digit;
  digit_addr_t        w_addr;
  logic [REG_W-1:0]   w_data;

  //////////////////////////////
  // Tick synchronizer and edge
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_tick_meta <= 1'b0;
      r_tick_sync <= 1'b0;
      r_tick_prev <= 1'b0;
      r_tick_rise <= 1'b0;
    end
    else
    begin
      r_tick_meta <= i_Frame_Tick;
      r_tick_sync <= r_tick_meta;
      r_tick_prev <= r_tick_sync;
      r_tick_rise <= r_tick_sync & ~r_tick_prev;  // Registered, one cycle wide
    end
  end

  // A start still in flight keeps ready high for one more cycle
  assign w_link_free  = link.ready & ~r_start;
  assign w_accept     = (r_state == IDLE) & r_tick_rise & i_Enable;  // Ticks elsewhere are lost
  assign w_load_setup = (r_state == SETUP) & w_link_free;
  assign w_load_digit = (r_state == ADDR_WAIT) & w_link_free;

  // Digit pick, tens digits are 3 bits wide
  always_comb
  begin
    case (r_digit_idx)
      3'd0:    w_digit = r_digits.cs_ones;
      3'd1:    w_digit = r_digits.cs_tens;
      3'd2:    w_digit = r_digits.sec_ones;
      3'd3:    w_digit = DIGIT_W'(r_digits.sec_tens);
      3'd4:    w_digit = r_digits.min_ones;
      3'd5:    w_digit = DIGIT_W'(r_digits.min_tens);
      default: w_digit = '0;
    endcase
  end

  assign w_addr = digit_addr_t'(r_digit_idx) + digit_addr_t'(1);  // Digit registers start at 1
  assign w_data = REG_W'(w_digit);                                  // Zero extend

  //////////////////////////////
  // Frame FSM
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state     <= SETUP;
      r_digit_idx <= '0;
      r_start     <= 1'b0;
    end
    else
    begin
      r_start <= 1'b0;  // Pulse by default
      case (r_state)
        SETUP:
        begin
          if (w_load_setup)
          begin
            r_start <= 1'b1;
            r_state <= IDLE;
          end
        end
        IDLE:
        begin
          if (w_accept)
          begin
            r_digit_idx <= '0;
            r_state     <= ADDR_WAIT;
          end
        end
        ADDR_WAIT:
        begin
          if (w_load_digit)
          begin
            r_start <= 1'b1;  // Word loads on the same edge
            r_state <= SEND;
          end
        end
        SEND:
        begin
          if (r_digit_idx == IDX_W'(NUM_DIGITS - 1))
            r_state <= IDLE;  // Sixth word started
          else
          begin
            r_digit_idx <= r_digit_idx + 1'b1;
            r_state     <= ADDR_WAIT;
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  // Word and snapshot registers
  always_ff @(posedge i_Clk)
  begin
    if (w_accept)
      r_digits <= i_Digits;
    if (w_load_setup)
      r_word <= word_t'({REG_DECODE_MODE, DECODE_ALL_BCD});
    else if (w_load_digit)
      r_word <= word_t'({w_addr, w_data});  // Address byte goes out first
  end

  assign link.word  = r_word;
  assign link.start = r_start;

  a_idx_range: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    r_digit_idx < NUM_DIGITS)
    else $error("Digit index out of range");

  // Timer must be idle and past its gap
  a_start_ready: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    link.start |-> link.ready)
    else $error("Start while the SPI engine is busy");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench, then search the log for the pass line

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_stopwatch_spi -f build.f \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_stopwatch_spi > sim.log 2>&1
cat sim.log

grep -qx "Result: PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== spi_bit_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

// Mode 0 only, SCLK idles low
module spi_bit_timer (
  input  logic      i_Clk,
  input  logic      i_Rst_L,
  spi_link_if.timer link,
  output logic      o_Spi_Clk,
  output logic      o_Spi_Cs_n
);

  import spi_pkg::*;

  logic [HALF_CNT_W-1:0] r_half_cnt;    // Position inside the current bit
  logic [EDGE_CNT_W-1:0] r_edges_left;  // SCLK edges still to come
  logic [GAP_CNT_W-1:0]  r_gap_cnt;     // CS high cycles before ready
  logic                  r_sclk;
  logic                  r_cs_n;
  logic                  r_ready;

  logic w_busy;
  logic w_rise_now;
  logic w_fall_now;
  logic w_last_edge;

  assign w_busy      = (r_edges_left != '0);
  assign w_rise_now  = w_busy & (r_half_cnt == HALF_CNT_W'(CLKS_PER_HALF_BIT - 1));
  assign w_fall_now  = w_busy & (r_half_cnt == HALF_CNT_W'(2 * CLKS_PER_HALF_BIT - 1));
  assign w_last_edge = (r_edges_left == EDGE_CNT_W'(1));  // Sixteenth fall

  //////////////////////////////
  // Edge, CS and gap counters
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_half_cnt   <= '0;
      r_edges_left <= '0;
      r_gap_cnt    <= '0;
      r_sclk       <= 1'b0;
      r_cs_n       <= 1'b1;
      r_ready      <= 1'b1;
    end
    else if (link.start)
    begin
      r_edges_left <= EDGE_CNT_W'(EDGES_PER_WORD);
      r_half_cnt   <= '0;
      r_cs_n       <= 1'b0;  // Low from the next cycle on
      r_ready      <= 1'b0;
    end
    else if (w_fall_now)
    begin
      r_sclk       <= 1'b0;
      r_half_cnt   <= '0;
      r_edges_left <= r_edges_left - 1'b1;
      if (w_last_edge)
      begin
        r_cs_n    <= 1'b1;  // Word done, CS rises with the last fall
        r_gap_cnt <= GAP_CNT_W'(CS_GAP_CLKS);
      end
    end
    else if (w_rise_now)
    begin
      r_sclk       <= 1'b1;  // End of first half bit
      r_half_cnt   <= r_half_cnt + 1'b1;
      r_edges_left <= r_edges_left - 1'b1;
    end
    else if (w_busy)
    begin
      r_half_cnt <= r_half_cnt + 1'b1;
    end
    else if (r_gap_cnt != '0)
    begin
      r_gap_cnt <= r_gap_cnt - 1'b1;
      if (r_gap_cnt == GAP_CNT_W'(1))
        r_ready <= 1'b1;  // Gap over
    end
  end

  // MOSI moves on every fall but the last
  assign link.shift = w_fall_now & ~w_last_edge;
  assign link.ready = r_ready;
  assign o_Spi_Clk  = r_sclk;
  assign o_Spi_Cs_n = r_cs_n;

  a_cs_not_ready: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    !o_Spi_Cs_n |-> !link.ready)
    else $error("Ready high during a CS low window");

endmodule

`default_nettype wire

// ==== spi_link_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Link between the word sequencer and the SPI engine
// start may only pulse while ready is high
interface spi_link_if;
  import spi_pkg::*;

  word_t word;   // Word to send, valid with start
  logic  start;  // One cycle pulse, begins a transfer
  logic  ready;  // Engine idle and the CS gap is over
  logic  shift;  // Move to the next bit, on SCLK fall

  // Sequencer side
  modport seq (
    output word,
    output start,
    input  ready
  );

  // Clock and chip select generator
  modport timer (
    input  start,
    output ready,
    output shift
  );

  // MOSI shift register
  modport shifter (
    input word,
    input start,
    input shift
  );

endinterface

`default_nettype wire

// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  //////////////////////////////
  // Word format and SCLK timing
  //////////////////////////////
  localparam int WORD_W            = 16;  // Address byte + data byte
  localparam int CLKS_PER_HALF_BIT = 2;   // i_Clk cycles per SCLK half period
  localparam int CS_GAP_CLKS       = 2;   // CS high time after a word

  // Derived counter sizes
  localparam int EDGES_PER_WORD = 2 * WORD_W;                    // One rise, one fall per bit
  localparam int HALF_CNT_W     = $clog2(2 * CLKS_PER_HALF_BIT); // Cycle count inside a bit
  localparam int EDGE_CNT_W     = $clog2(EDGES_PER_WORD + 1);    // Holds 0 to 32
  localparam int GAP_CNT_W      = $clog2(CS_GAP_CLKS + 1);

  typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

// ==== spi_word_shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_word_shifter (
  input  logic        i_Clk,
  input  logic        i_Rst_L,
  spi_link_if.shifter link,
  output logic        o_Spi_Mosi
);

  import spi_pkg::*;

  word_t r_shift_reg;  // MSB is on the wire

  //////////////////////////////
  // Load and shift
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_shift_reg <= '0;  // MOSI low out of reset
    end
    else if (link.start)
    begin
      r_shift_reg <= link.word;  // Bit 15 shows with CS low
    end
    else if (link.shift)
    begin
      r_shift_reg <= {r_shift_reg[WORD_W-2:0], 1'b0};  // Next bit on SCLK fall
    end
  end

  // Stable across every SCLK rise
  assign o_Spi_Mosi = r_shift_reg[WORD_W-1];

  // Start comes from the sequencer, shift from the timer
  a_no_shift_at_load: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    link.start |-> !link.shift)
    else $error("Shift strobe in the cycle of a start");

endmodule

`default_nettype wire

// ==== stopwatch_spi_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module stopwatch_spi_top (
  input  logic                        i_Clk,
  input  logic                        i_Rst_L,
  input  logic                        i_Frame_Tick,  // Slow frame rate tick
  input  logic                        i_Enable,
  input  logic [display_pkg::TENS6_W-1:0] i_Min_Tens,
  input  logic [display_pkg::DIGIT_W-1:0] i_Min_Ones,
  input  logic [display_pkg::TENS6_W-1:0] i_Sec_Tens,
  input  logic [display_pkg::DIGIT_W-1:0] i_Sec_Ones,
  input  logic [display_pkg::DIGIT_W-1:0] i_Cs_Tens,
  input  logic [display_pkg::DIGIT_W-1:0] i_Cs_Ones,
  output logic                        o_Spi_Clk,
  output logic                        o_Spi_Mosi,
  output logic                        o_Spi_Cs_n
);

  import display_pkg::*;

  digits_t w_digits;

  // Pack in send order
  assign w_digits.cs_ones  = i_Cs_Ones;
  assign w_digits.cs_tens  = i_Cs_Tens;
  assign w_digits.sec_ones = i_Sec_Ones;
  assign w_digits.sec_tens = i_Sec_Tens;
  assign w_digits.min_ones = i_Min_Ones;
  assign w_digits.min_tens = i_Min_Tens;

  spi_link_if u_link ();

  //////////////////////////////
  // Word source
  //////////////////////////////
  display_sequencer u_display_sequencer (
    .i_Clk        (i_Clk),
    .i_Rst_L      (i_Rst_L),
    .i_Frame_Tick (i_Frame_Tick),
    .i_Enable     (i_Enable),
    .i_Digits     (w_digits),
    .link         (u_link)
  );

  //////////////////////////////
  // SPI engine
  //////////////////////////////
  spi_bit_timer u_spi_bit_timer (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .link       (u_link),
    .o_Spi_Clk  (o_Spi_Clk),
    .o_Spi_Cs_n (o_Spi_Cs_n)
  );

  spi_word_shifter u_spi_word_shifter (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .link       (u_link),
    .o_Spi_Mosi (o_Spi_Mosi)  // MSB first
  );

endmodule

`default_nettype wire

// ==== tb_stopwatch_spi.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_stopwatch_spi;

  import display_pkg::*;
  import spi_pkg::*;

  localparam int WINDOW_CLKS   = WORD_W * 2 * CLKS_PER_HALF_BIT;  // CS low time per word
  localparam int FRAME_CLKS    = NUM_DIGITS * (WINDOW_CLKS + 8) + 40;  // Six words and tick delay
  localparam int WATCHDOG_CLKS = 12 * NUM_DIGITS * 70 + 2000;     // 12 frames plus margin

  logic               i_Clk;
  logic               i_Rst_L;
  logic               i_Frame_Tick;
  logic               i_Enable;
  logic [TENS6_W-1:0] i_Min_Tens, i_Sec_Tens;
  logic [DIGIT_W-1:0] i_Min_Ones, i_Sec_Ones, i_Cs_Tens, i_Cs_Ones;
  logic               o_Spi_Clk, o_Spi_Mosi, o_Spi_Cs_n;

  logic [31:0] lfsr_state;
  word_t       exp_q[$];         // Words the DUT still owes
  int          error_count = 0;
  int          word_count;
  int          window_count;     // Completed CS low windows

  // Monitor state, sampled on the falling clock edge
  logic  prev_cs_n;
  logic  prev_sclk;
  word_t rx_word;
  word_t exp_word;
  int    rise_cnt;
  int    low_clks;
  int    high_clks;

  stopwatch_spi_top u_stopwatch_spi_top (
    .i_Clk        (i_Clk),
    .i_Rst_L      (i_Rst_L),
    .i_Frame_Tick (i_Frame_Tick),
    .i_Enable     (i_Enable),
    .i_Min_Tens   (i_Min_Tens),
    .i_Min_Ones   (i_Min_Ones),
    .i_Sec_Tens   (i_Sec_Tens),
    .i_Sec_Ones   (i_Sec_Ones),
    .i_Cs_Tens    (i_Cs_Tens),
    .i_Cs_Ones    (i_Cs_Ones),
    .o_Spi_Clk    (o_Spi_Clk),
    .o_Spi_Mosi   (o_Spi_Mosi),
    .o_Spi_Cs_n   (o_Spi_Cs_n)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #4 i_Clk = ~i_Clk;  // 8 ns period
  end

  task automatic note_fail(input string msg);
    error_count++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_digit(input int nbits, input int limit, output logic [3:0] d);
    logic [3:0] raw;
    raw = '0;
    for (int b = 0; b < nbits; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      raw = {raw[2:0], lfsr_state[0]};
    end
    d = 4'(raw % limit);
  endtask

  task automatic randomize_digits();
    logic [3:0] d;
    pick_digit(4, 10, d);
    i_Cs_Ones = d;
    pick_digit(4, 10, d);
    i_Cs_Tens = d;
    pick_digit(4, 10, d);
    i_Sec_Ones = d;
    pick_digit(3, 6, d);
    i_Sec_Tens = d[2:0];  // Tens limited to 0..5
    pick_digit(4, 10, d);
    i_Min_Ones = d;
    pick_digit(3, 6, d);
    i_Min_Tens = d[2:0];
  endtask

  // Six words from the digits held at the tick, address n+1
  task automatic push_frame_words();
    logic [3:0] digit [NUM_DIGITS];
    digit[0] = i_Cs_Ones;
    digit[1] = i_Cs_Tens;
    digit[2] = i_Sec_Ones;
    digit[3] = {1'b0, i_Sec_Tens};
    digit[4] = i_Min_Ones;
    digit[5] = {1'b0, i_Min_Tens};
    for (int n = 0; n < NUM_DIGITS; n++)
      exp_q.push_back({8'(n + 1), 4'h0, digit[n]});  // Data byte zero extended
  endtask

  task automatic pulse_tick();
    i_Frame_Tick = 1'b1;
    repeat (4) @(negedge i_Clk);
    i_Frame_Tick = 1'b0;
  endtask

  // Gives up after one frame time, words still owed stay in the queue
  task automatic wait_words_done();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < FRAME_CLKS)
    begin
      @(negedge i_Clk);
      waited++;
    end
    repeat (CS_GAP_CLKS + 4) @(negedge i_Clk);  // Let the CS gap run out
  endtask

  task automatic run_frame(input bit change_late);
    randomize_digits();
    @(negedge i_Clk);
    push_frame_words();
    pulse_tick();
    if (change_late)
    begin
      repeat (4) @(negedge i_Clk);  // 8 cycles after the tick
      randomize_digits();           // Snapshot already taken
    end
    wait_words_done();
  endtask

  //////////////////////////////
  // SPI word monitor
  //////////////////////////////
  task automatic check_window();
    window_count++;
    assert (rise_cnt == WORD_W)
      else note_fail($sformatf("%0d SCLK rises in a CS window, expected %0d", rise_cnt, WORD_W));
    assert (low_clks == WINDOW_CLKS)
      else note_fail($sformatf("CS low %0d cycles, expected %0d", low_clks, WINDOW_CLKS));
    assert (exp_q.size() != 0)
      else note_fail($sformatf("Unexpected word %h with no word pending", rx_word));
    if (exp_q.size() != 0)
    begin
      exp_word = exp_q.pop_front();
      word_count++;
      assert (rx_word == exp_word)
        else note_fail($sformatf("Word %h, expected %h", rx_word, exp_word));
    end
  endtask

  always @(negedge i_Clk)
  begin
    if (!i_Rst_L)
    begin
      prev_cs_n    = 1'b1;
      prev_sclk    = 1'b0;
      high_clks    = 0;
      window_count = 0;
      word_count   = 0;
    end
    else
    begin
      if (!o_Spi_Cs_n)
      begin
        if (prev_cs_n)
        begin
          if (window_count > 0)  // Gap, then at least one ready cycle for the start
            assert (high_clks >= CS_GAP_CLKS + 1)
              else note_fail($sformatf("CS high only %0d cycles between words", high_clks));
          rx_word  = '0;
          rise_cnt = 0;
          low_clks = 0;
        end
        low_clks++;
        if (o_Spi_Clk && !prev_sclk)
        begin
          rx_word = {rx_word[WORD_W-2:0], o_Spi_Mosi};  // MSB first
          rise_cnt++;
        end
      end
      else if (!prev_cs_n)
      begin
        check_window();  // CS just rose
        high_clks = 1;
      end
      else
        high_clks++;
      prev_cs_n = o_Spi_Cs_n;
      prev_sclk = o_Spi_Clk;
    end
  end

  // Mode 0 SCLK idles low outside a word
  a_sclk_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    o_Spi_Cs_n |-> !o_Spi_Clk)
    else note_fail("SCLK high while CS is high");

  a_rise_in_window: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    $rose(o_Spi_Clk) |-> !o_Spi_Cs_n)
    else note_fail("SCLK rose outside a CS window");

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    int windows_before;
    lfsr_state   = 32'h165a;
    i_Rst_L      = 1'b0;
    i_Frame_Tick = 1'b0;
    i_Enable     = 1'b1;
    i_Min_Tens   = '0;
    i_Min_Ones   = '0;
    i_Sec_Tens   = '0;
    i_Sec_Ones   = '0;
    i_Cs_Tens    = '0;
    i_Cs_Ones    = '0;
    exp_q.push_back(16'h09FF);  // Decode mode, BCD on all digits
    repeat (5) @(negedge i_Clk);
    i_Rst_L = 1'b1;
    assert (o_Spi_Cs_n === 1'b1 && o_Spi_Clk === 1'b0)
      else note_fail("CS or SCLK not idle after reset");
    wait_words_done();

    for (int f = 0; f < 6; f++)
      run_frame(1'b0);
    run_frame(1'b1);  // Late digit change

    // Tick with enable low
    windows_before = window_count;
    i_Enable = 1'b0;
    pulse_tick();
    repeat (WINDOW_CLKS + 40) @(negedge i_Clk);  // A first word would be complete by now
    assert (window_count == windows_before)
      else note_fail("Words sent for a tick with enable low");
    i_Enable = 1'b1;

    // Second tick inside a running frame
    windows_before = window_count;
    randomize_digits();
    @(negedge i_Clk);
    push_frame_words();
    pulse_tick();
    repeat (100) @(negedge i_Clk);
    randomize_digits();
    pulse_tick();
    wait_words_done();
    repeat (WINDOW_CLKS + 40) @(negedge i_Clk);  // Room for one extra word
    assert (window_count == windows_before + NUM_DIGITS)
      else note_fail("Extra words after a tick during a frame");
    assert (exp_q.size() == 0)
      else note_fail($sformatf("%0d expected words never sent", exp_q.size()));

    $display("Errors: %0d, words checked: %0d", error_count, word_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CLKS) @(posedge i_Clk);
    $display("Watchdog expired before the test sequence finished");
    $display("Errors: %0d, words checked: %0d", error_count, word_count);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
